// ==== stk_engine.f ====
source/stk_pkg.sv
source/stk_cmd_in.sv
source/stk_lookup.sv
source/stk_bank_mem.sv
source/stk_rsp_out.sv
source/stk_top.sv
bench/stk_chk.sv
bench/stk_tb.sv

// ==== Makefile ====
# Verilator build and run for the stack engine testbench

VERILATOR ?= verilator
TOP       ?= stk_tb
FILELIST  ?= stk_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
SIM_ARGS  ?= +verilator+error+limit+$(ERR_LIMIT)

PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG TIMESCALE ERR_LIMIT VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "FAIL see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/stk_stimulus.txt ====
# op eng full ptr dat exp_status exp_ptr exp_dat (all hex)
# op 1 push 2 pop 3 inv / status 0 okay 1 empty error 2 full error
3 3 0 0 00000000 1 0 00000000
2 2 0 0 00000000 1 0 00000000
1 0 0 1 11111111 0 1 00000000
1 0 0 9 22222222 0 9 00000000
1 0 0 2 33333333 0 2 00000000
2 0 0 0 00000000 0 2 33333333
2 0 0 0 00000000 0 9 22222222
2 0 0 0 00000000 0 1 11111111
2 0 0 0 00000000 1 0 00000000
1 0 0 3 44444444 0 3 00000000
1 1 0 a aaaa0001 0 a 00000000
1 2 0 4 bbbb0001 0 4 00000000
1 1 0 b aaaa0002 0 b 00000000
1 2 0 5 bbbb0002 0 5 00000000
2 1 0 0 00000000 0 b aaaa0002
2 2 0 0 00000000 0 5 bbbb0002
1 1 0 c aaaa0003 0 c 00000000
2 1 0 0 00000000 0 c aaaa0003
2 1 0 0 00000000 0 a aaaa0001
2 2 0 0 00000000 0 4 bbbb0001
1 0 1 6 deadbeef 2 0 00000000
2 0 0 0 00000000 0 3 44444444
1 3 0 7 cccc0001 0 7 00000000
1 3 0 d cccc0002 0 d 00000000
3 3 0 0 00000000 0 d 00000000
2 3 0 0 00000000 0 7 cccc0001
3 3 0 0 00000000 1 0 00000000
2 0 0 0 00000000 1 0 00000000

// ==== bench/stk_tb.sv ====
// Stack engine testbench
// Replays the command list from the stimulus file, one command per
// cycle, and compares each response with the listed status, pointer
// and data
module stk_tb import stk_pkg::*; ();
timeunit 1ns;
timeprecision 100ps;

localparam int    ENG_W     = $clog2(ENGS_N_DEF);
localparam int    PTR_W     = $clog2(BANKS_N_DEF) + $clog2(LINES_N_DEF);
localparam int    DAT_W     = DAT_W_DEF;
localparam string STIM_FILE = "bench/stk_stimulus.txt";

logic             clk;
logic             i_rst_n;
logic             i_cmd_vld;
opcode_e          i_cmd_op;
logic [ENG_W-1:0] i_cmd_engid;
logic             i_cmd_full;
logic [PTR_W-1:0] i_cmd_ptr;
logic [DAT_W-1:0] i_cmd_dat;
logic             o_rsp_vld;
opcode_e          o_rsp_op;
logic [ENG_W-1:0] o_rsp_engid;
status_e          o_rsp_status;
logic [PTR_W-1:0] o_rsp_ptr;
logic [DAT_W-1:0] o_rsp_dat;

// Commands as read from the file
opcode_e          stim_op   [$];
logic [ENG_W-1:0] stim_eng  [$];
logic             stim_full [$];
logic [PTR_W-1:0] stim_ptr  [$];
logic [DAT_W-1:0] stim_dat  [$];
status_e          stim_sts  [$];
logic [PTR_W-1:0] stim_eptr [$];
logic [DAT_W-1:0] stim_edat [$];

// Expected responses in flight
opcode_e          exp_op  [$];
logic [ENG_W-1:0] exp_eng [$];
status_e          exp_sts [$];
logic [PTR_W-1:0] exp_ptr [$];
logic [DAT_W-1:0] exp_dat [$];
int               exp_idx [$];

int check_errs  = 0;
int proto_errs  = 0;
int total_errs  = 0;
int cycle_cnt   = 0;
int cycle_limit = 0;
int rsp_idx;

stk_top #(
  .ENGS_N(ENGS_N_DEF), .BANKS_N(BANKS_N_DEF), .LINES_N(LINES_N_DEF), .DAT_W(DAT_W_DEF)
) DUT (
  .clk, .i_rst_n
, .i_cmd_vld, .i_cmd_op, .i_cmd_engid, .i_cmd_full, .i_cmd_ptr, .i_cmd_dat
, .o_rsp_vld, .o_rsp_op, .o_rsp_engid, .o_rsp_status, .o_rsp_ptr, .o_rsp_dat
);

bind stk_top stk_chk #(.DAT_W(DAT_W)) u_chk (
  .clk, .i_rst_n, .i_cmd_vld, .o_rsp_vld, .o_rsp_op, .o_rsp_status, .o_rsp_dat
);

initial begin
  clk = 1'b0;
  forever #5 clk = ~clk;
end

always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

task automatic load_stimulus();
  int               fd;
  int               n;
  string            line;
  logic [1:0]       op_f;
  logic [ENG_W-1:0] eng_f;
  logic             full_f;
  logic [PTR_W-1:0] ptr_f;
  logic [DAT_W-1:0] dat_f;
  logic [1:0]       sts_f;
  logic [PTR_W-1:0] eptr_f;
  logic [DAT_W-1:0] edat_f;
  fd = $fopen(STIM_FILE, "r");
  if (fd == 0) begin
    proto_errs++;
    $display("Could not open the stimulus file %s", STIM_FILE);
  end else begin
    while ($fgets(line, fd) != 0) begin
      // Comment and blank lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                  op_f, eng_f, full_f, ptr_f, dat_f, sts_f, eptr_f, edat_f);
      if (n != 8) begin
        proto_errs++;
        $display("Stimulus line has %0d fields instead of 8: %s", n, line);
      end else begin
        stim_op.push_back(opcode_e'(op_f));
        stim_eng.push_back(eng_f);
        stim_full.push_back(full_f);
        stim_ptr.push_back(ptr_f);
        stim_dat.push_back(dat_f);
        stim_sts.push_back(status_e'(sts_f));
        stim_eptr.push_back(eptr_f);
        stim_edat.push_back(edat_f);
      end
    end
    $fclose(fd);
  end
endtask

// Apply one command and queue what it must return
task automatic drive_command(input int i);
  i_cmd_vld   = 1'b1;
  i_cmd_op    = stim_op[i];
  i_cmd_engid = stim_eng[i];
  i_cmd_full  = stim_full[i];
  i_cmd_ptr   = stim_ptr[i];
  i_cmd_dat   = stim_dat[i];
  // Response echoes the command's opcode and engine
  exp_op.push_back(stim_op[i]);
  exp_eng.push_back(stim_eng[i]);
  exp_sts.push_back(stim_sts[i]);
  exp_ptr.push_back(stim_eptr[i]);
  exp_dat.push_back(stim_edat[i]);
  exp_idx.push_back(i);
endtask

task automatic check_op(input opcode_e got, input opcode_e exp, input int idx);
  if (got !== exp) begin
    check_errs++;
    $display("CHECK FAILED at %0t: command %0d opcode %s, expected %s",
             $time, idx, got.name(), exp.name());
  end
endtask

task automatic check_engid(input logic [ENG_W-1:0] got, input logic [ENG_W-1:0] exp,
                           input int idx);
  if (got !== exp) begin
    check_errs++;
    $display("CHECK FAILED at %0t: command %0d engine %0d, expected %0d",
             $time, idx, got, exp);
  end
endtask

task automatic check_status(input status_e got, input status_e exp, input int idx);
  if (got !== exp) begin
    check_errs++;
    $display("CHECK FAILED at %0t: command %0d status %s, expected %s",
             $time, idx, got.name(), exp.name());
  end
endtask

task automatic check_ptr(input logic [PTR_W-1:0] got, input logic [PTR_W-1:0] exp,
                         input int idx);
  if (got !== exp) begin
    check_errs++;
    $display("CHECK FAILED at %0t: command %0d pointer %h, expected %h",
             $time, idx, got, exp);
  end
endtask

task automatic check_dat(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                         input int idx);
  if (got !== exp) begin
    check_errs++;
    $display("CHECK FAILED at %0t: command %0d data %h, expected %h",
             $time, idx, got, exp);
  end
endtask

// Responses are sampled on the falling clock edge
always @(negedge clk) begin
  if (i_rst_n && o_rsp_vld) begin
    if (exp_sts.size() == 0) begin
      proto_errs++;
      $display("Response at %0t arrived with no command outstanding", $time);
    end else begin
      rsp_idx = exp_idx.pop_front();
      check_op(o_rsp_op, exp_op.pop_front(), rsp_idx);
      check_engid(o_rsp_engid, exp_eng.pop_front(), rsp_idx);
      check_status(o_rsp_status, exp_sts.pop_front(), rsp_idx);
      check_ptr(o_rsp_ptr, exp_ptr.pop_front(), rsp_idx);
      check_dat(o_rsp_dat, exp_dat.pop_front(), rsp_idx);
    end
  end
end

initial begin
  i_rst_n     = 1'b0;
  i_cmd_vld   = 1'b0;
  i_cmd_op    = OP_NOP;
  i_cmd_engid = '0;
  i_cmd_full  = 1'b0;
  i_cmd_ptr   = '0;
  i_cmd_dat   = '0;
  load_stimulus();
  // Reset cycles plus two per command plus slack
  cycle_limit = 16 + 2 * stim_op.size() + 20;
  repeat (16) @(posedge clk);
  #1 i_rst_n = 1'b1;
  foreach (stim_op[i]) begin
    @(posedge clk);
    #1;
    drive_command(i);
  end
  @(posedge clk);
  #1;
  i_cmd_vld = 1'b0;
  i_cmd_op  = OP_NOP;
  // Wait for the outstanding responses
  while (exp_sts.size() != 0) @(posedge clk);
  total_errs = check_errs + proto_errs + DUT.u_chk.fail_cnt;
  $display("Errors %0d compare, %0d protocol, %0d assertion",
           check_errs, proto_errs, DUT.u_chk.fail_cnt);
  if (total_errs == 0) begin
    $display("All tests passed");
  end else begin
    $display("Some tests failed");
  end
  $finish;
end

// Timeout
initial begin
  wait (cycle_limit != 0);
  while (cycle_cnt < cycle_limit) @(posedge clk);
  $display("Timeout after %0d cycles with %0d responses never received, %0d compare errors",
           cycle_cnt, exp_sts.size(), check_errs);
  $display("Some tests failed");
  $finish;
end

endmodule : stk_tb

// ==== bench/stk_chk.sv ====
// Stack engine protocol checker
// Bound to the top level. Watches the fixed response latency, a quiet
// response strobe in reset and the data zeroing rule
module stk_chk import stk_pkg::*; #(
  parameter int DAT_W = DAT_W_DEF
) (
  input  logic             clk
, input  logic             i_rst_n
, input  logic             i_cmd_vld
, input  logic             o_rsp_vld
, input  opcode_e          o_rsp_op
, input  status_e          o_rsp_status
, input  logic [DAT_W-1:0] o_rsp_dat
);
timeunit 1ns;
timeprecision 100ps;

// Failed assertions so far
int fail_cnt = 0;

// Every command strobe gets its response two edges later
a_rsp_after_cmd: assert property (
  @(posedge clk) disable iff (!i_rst_n) i_cmd_vld |-> ##2 o_rsp_vld
) else begin
  fail_cnt = fail_cnt + 1;
  $error("Response strobe missing two cycles after a command");
end

// No response without a command two cycles back
a_cmd_before_rsp: assert property (
  @(posedge clk) disable iff (!i_rst_n) o_rsp_vld |-> $past(i_cmd_vld, 2)
) else begin
  fail_cnt = fail_cnt + 1;
  $error("Response strobe without a matching command");
end

a_rst_quiet: assert property (
  @(posedge clk) !i_rst_n |-> !o_rsp_vld
) else begin
  fail_cnt = fail_cnt + 1;
  $error("Response strobe high during reset");
end

// Data only travels with a successful pop
a_dat_zero: assert property (
  @(posedge clk) disable iff (!i_rst_n)
  o_rsp_vld && !(o_rsp_status == ST_OKAY && o_rsp_op == OP_POP) |-> o_rsp_dat == '0
) else begin
  fail_cnt = fail_cnt + 1;
  $error("Response data not zero outside a successful pop");
end

endmodule : stk_chk

// ==== source/stk_top.sv ====
// Stack engine top level
// Command input stage, lookup, link/data banks and response stage.
// Two cycles from command strobe to response strobe
module stk_top import stk_pkg::*; #(
  parameter int  ENGS_N  = ENGS_N_DEF
, parameter int  BANKS_N = BANKS_N_DEF
, parameter int  LINES_N = LINES_N_DEF
, parameter int  DAT_W   = DAT_W_DEF
, localparam int ENG_W   = $clog2(ENGS_N)
, localparam int LINE_W  = $clog2(LINES_N)
, localparam int PTR_W   = $clog2(BANKS_N) + LINE_W
) (
  input  logic             clk
, input  logic             i_rst_n
  // Command
, input  logic             i_cmd_vld
, input  opcode_e          i_cmd_op
, input  logic [ENG_W-1:0] i_cmd_engid
, input  logic             i_cmd_full
, input  logic [PTR_W-1:0] i_cmd_ptr
, input  logic [DAT_W-1:0] i_cmd_dat
  // Response
, output logic             o_rsp_vld
, output opcode_e          o_rsp_op
, output logic [ENG_W-1:0] o_rsp_engid
, output status_e          o_rsp_status
, output logic [PTR_W-1:0] o_rsp_ptr
, output logic [DAT_W-1:0] o_rsp_dat
);

// Input stage to lookup
logic             lk_vld;
opcode_e          lk_op;
logic             lk_is_push;
logic             lk_is_pop;
logic             lk_is_inv;
logic [ENG_W-1:0] lk_engid;
logic             lk_full;
logic [PTR_W-1:0] lk_ptr;
logic [DAT_W-1:0] lk_dat;

// Lookup to banks
logic [BANKS_N-1:0]             bk_wen;
logic [BANKS_N-1:0][LINE_W-1:0] bk_wr_line;
logic [BANKS_N-1:0][PTR_W-1:0]  bk_wr_link;
logic [BANKS_N-1:0][DAT_W-1:0]  bk_wr_dat;
logic [BANKS_N-1:0][LINE_W-1:0] bk_rd_line;
logic [BANKS_N-1:0][PTR_W-1:0]  bk_rd_link;
logic [BANKS_N-1:0][DAT_W-1:0]  bk_rd_dat;

// Lookup to response stage
logic             rs_vld;
opcode_e          rs_op;
logic [ENG_W-1:0] rs_engid;
status_e          rs_status;
logic [PTR_W-1:0] rs_ptr;
logic [DAT_W-1:0] rs_dat;

stk_cmd_in #(
  .ENGS_N(ENGS_N), .BANKS_N(BANKS_N), .LINES_N(LINES_N), .DAT_W(DAT_W)
) u_cmd_in (
  .clk, .i_rst_n
, .i_cmd_vld, .i_cmd_op, .i_cmd_engid, .i_cmd_full, .i_cmd_ptr, .i_cmd_dat
, .o_lk_vld(lk_vld), .o_lk_op(lk_op), .o_lk_is_push(lk_is_push)
, .o_lk_is_pop(lk_is_pop), .o_lk_is_inv(lk_is_inv), .o_lk_engid(lk_engid)
, .o_lk_full(lk_full), .o_lk_ptr(lk_ptr), .o_lk_dat(lk_dat)
);

stk_lookup #(
  .ENGS_N(ENGS_N), .BANKS_N(BANKS_N), .LINES_N(LINES_N), .DAT_W(DAT_W)
) u_lookup (
  .clk, .i_rst_n
, .i_lk_vld(lk_vld), .i_lk_op(lk_op), .i_lk_is_push(lk_is_push)
, .i_lk_is_pop(lk_is_pop), .i_lk_is_inv(lk_is_inv), .i_lk_engid(lk_engid)
, .i_lk_full(lk_full), .i_lk_ptr(lk_ptr), .i_lk_dat(lk_dat)
, .i_bank_rd_link(bk_rd_link), .i_bank_rd_dat(bk_rd_dat)
, .o_bank_wen(bk_wen), .o_bank_wr_line(bk_wr_line), .o_bank_wr_link(bk_wr_link)
, .o_bank_wr_dat(bk_wr_dat), .o_bank_rd_line(bk_rd_line)
, .o_rsp_vld(rs_vld), .o_rsp_op(rs_op), .o_rsp_engid(rs_engid)
, .o_rsp_status(rs_status), .o_rsp_ptr(rs_ptr), .o_rsp_dat(rs_dat)
);

// One storage bank per pointer bank id
for (genvar b = 0; b < BANKS_N; b++) begin : g_bank
  stk_bank_mem #(.LINES_N(LINES_N), .PTR_W(PTR_W), .DAT_W(DAT_W)) u_bank_mem (
    .clk
  , .i_wen(bk_wen[b]), .i_wr_line(bk_wr_line[b]), .i_wr_link(bk_wr_link[b])
  , .i_wr_dat(bk_wr_dat[b]), .i_rd_line(bk_rd_line[b])
  , .o_rd_link(bk_rd_link[b]), .o_rd_dat(bk_rd_dat[b])
  );
end : g_bank

stk_rsp_out #(.ENGS_N(ENGS_N), .PTR_W(PTR_W), .DAT_W(DAT_W)) u_rsp_out (
  .clk, .i_rst_n
, .i_vld(rs_vld), .i_op(rs_op), .i_engid(rs_engid), .i_status(rs_status)
, .i_ptr(rs_ptr), .i_dat(rs_dat)
, .o_rsp_vld, .o_rsp_op, .o_rsp_engid, .o_rsp_status, .o_rsp_ptr, .o_rsp_dat
);

endmodule : stk_top

// ==== source/stk_rsp_out.sv ====
// Stack engine response output stage
// Registers the resolved response; pointer is cleared on errors and
// data is cleared for anything but a successful pop
module stk_rsp_out import stk_pkg::*; #(
  parameter int  ENGS_N = ENGS_N_DEF
, parameter int  PTR_W  = $clog2(BANKS_N_DEF) + $clog2(LINES_N_DEF)
, parameter int  DAT_W  = DAT_W_DEF
, localparam int ENG_W  = $clog2(ENGS_N)
) (
  input  logic             clk
, input  logic             i_rst_n
  // From lookup
, input  logic             i_vld
, input  opcode_e          i_op
, input  logic [ENG_W-1:0] i_engid
, input  status_e          i_status
, input  logic [PTR_W-1:0] i_ptr
, input  logic [DAT_W-1:0] i_dat
  // To the caller
, output logic             o_rsp_vld
, output opcode_e          o_rsp_op
, output logic [ENG_W-1:0] o_rsp_engid
, output status_e          o_rsp_status
, output logic [PTR_W-1:0] o_rsp_ptr
, output logic [DAT_W-1:0] o_rsp_dat
);

logic okay;
logic pop_okay;

assign okay     = (i_status == ST_OKAY);
assign pop_okay = okay & (i_op == OP_POP);

always_ff @(posedge clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    o_rsp_vld <= 1'b0;
  end else begin
    o_rsp_vld <= i_vld;
  end
end

// Error pointers never reach the caller's allocator
always_ff @(posedge clk) begin
  if (i_vld) begin
    o_rsp_op     <= i_op;
    o_rsp_engid  <= i_engid;
    o_rsp_status <= i_status;
    o_rsp_ptr    <= okay ? i_ptr : '0;
    o_rsp_dat    <= pop_okay ? i_dat : '0;
  end
end

endmodule : stk_rsp_out

// ==== source/stk_bank_mem.sv ====
// Stack engine storage bank
// Each line keeps the link to the entry below it and the data word.
// One write per edge, one combinational read
module stk_bank_mem import stk_pkg::*; #(
  parameter int  LINES_N = LINES_N_DEF
, parameter int  PTR_W   = $clog2(BANKS_N_DEF) + $clog2(LINES_N_DEF)
, parameter int  DAT_W   = DAT_W_DEF
, localparam int LINE_W  = $clog2(LINES_N)
) (
  input  logic              clk
  // Write port
, input  logic              i_wen
, input  logic [LINE_W-1:0] i_wr_line
, input  logic [PTR_W-1:0]  i_wr_link
, input  logic [DAT_W-1:0]  i_wr_dat
  // Read port
, input  logic [LINE_W-1:0] i_rd_line
, output logic [PTR_W-1:0]  o_rd_link
, output logic [DAT_W-1:0]  o_rd_dat
);

// Link and data arrays
logic [PTR_W-1:0] link_mem [LINES_N];
logic [DAT_W-1:0] dat_mem  [LINES_N];

// Lines are written by a push before any pop reads them
always_ff @(posedge clk) begin
  if (i_wen) begin
    link_mem[i_wr_line] <= i_wr_link;
    dat_mem[i_wr_line]  <= i_wr_dat;
  end
end

// Read sees the contents before this edge's write
assign o_rd_link = link_mem[i_rd_line];
assign o_rd_dat  = dat_mem[i_rd_line];

endmodule : stk_bank_mem

// ==== source/stk_lookup.sv ====
// Stack engine lookup stage
// Keeps head, tail and empty state per engine, resolves the command
// status and drives the per-bank link and data accesses. State and
// bank writes land at the next edge, so back-to-back commands chain
module stk_lookup import stk_pkg::*; #(
  parameter int  ENGS_N  = ENGS_N_DEF
, parameter int  BANKS_N = BANKS_N_DEF
, parameter int  LINES_N = LINES_N_DEF
, parameter int  DAT_W   = DAT_W_DEF
, localparam int ENG_W   = $clog2(ENGS_N)
, localparam int BNK_W   = $clog2(BANKS_N)
, localparam int LINE_W  = $clog2(LINES_N)
, localparam int PTR_W   = BNK_W + LINE_W
) (
  input  logic                              clk
, input  logic                              i_rst_n
  // Registered command
, input  logic                              i_lk_vld
, input  opcode_e                           i_lk_op
, input  logic                              i_lk_is_push
, input  logic                              i_lk_is_pop
, input  logic                              i_lk_is_inv
, input  logic [ENG_W-1:0]                  i_lk_engid
, input  logic                              i_lk_full
, input  logic [PTR_W-1:0]                  i_lk_ptr
, input  logic [DAT_W-1:0]                  i_lk_dat
  // Bank read data, combinational
, input  logic [BANKS_N-1:0][PTR_W-1:0]     i_bank_rd_link
, input  logic [BANKS_N-1:0][DAT_W-1:0]     i_bank_rd_dat
  // Bank access
, output logic [BANKS_N-1:0]                o_bank_wen
, output logic [BANKS_N-1:0][LINE_W-1:0]    o_bank_wr_line
, output logic [BANKS_N-1:0][PTR_W-1:0]     o_bank_wr_link
, output logic [BANKS_N-1:0][DAT_W-1:0]     o_bank_wr_dat
, output logic [BANKS_N-1:0][LINE_W-1:0]    o_bank_rd_line
  // Resolved response
, output logic                              o_rsp_vld
, output opcode_e                           o_rsp_op
, output logic [ENG_W-1:0]                  o_rsp_engid
, output status_e                           o_rsp_status
, output logic [PTR_W-1:0]                  o_rsp_ptr
, output logic [DAT_W-1:0]                  o_rsp_dat
);

// Per-engine tables
logic [PTR_W-1:0]  head_r [ENGS_N];
logic [PTR_W-1:0]  tail_r [ENGS_N];
logic [ENGS_N-1:0] empty_r;

// Addressed engine
logic [PTR_W-1:0]  head_cur;
logic [PTR_W-1:0]  tail_cur;
logic              eng_empty;

// Status and qualified actions
logic              err_empty;
logic              err_full;
logic              push_ok;
logic              pull_ok;

// Bank selection and read return
logic [BNK_W-1:0]  push_bank;
logic [BNK_W-1:0]  head_bank;
logic [PTR_W-1:0]  rd_link;
logic [DAT_W-1:0]  rd_dat;

assign head_cur  = head_r[i_lk_engid];
assign tail_cur  = tail_r[i_lk_engid];
assign eng_empty = empty_r[i_lk_engid];

// Bank id sits in the upper pointer bits
assign push_bank = i_lk_ptr[PTR_W-1 -: BNK_W];
assign head_bank = head_cur[PTR_W-1 -: BNK_W];

// Pop or invalidate with nothing stacked
assign err_empty = (i_lk_is_pop | i_lk_is_inv) & eng_empty;
// Push while the caller has no free slot
assign err_full  = i_lk_is_push & i_lk_full;

assign push_ok = i_lk_is_push & ~i_lk_full;
assign pull_ok = (i_lk_is_pop | i_lk_is_inv) & ~eng_empty;

// Push writes old head as link at the new slot; pops read at head
for (genvar b = 0; b < BANKS_N; b++) begin : g_bank
  assign o_bank_wen[b]     = push_ok & (push_bank == BNK_W'(b));
  assign o_bank_wr_line[b] = i_lk_ptr[LINE_W-1:0];
  assign o_bank_wr_link[b] = head_cur;
  assign o_bank_wr_dat[b]  = i_lk_dat;
  assign o_bank_rd_line[b] = head_cur[LINE_W-1:0];
end : g_bank

// Only the head's bank returns meaningful data
assign rd_link = i_bank_rd_link[head_bank];
assign rd_dat  = i_bank_rd_dat[head_bank];

always_comb begin
  if (err_empty) begin
    o_rsp_status = ST_ERREMPTY;
  end else if (err_full) begin
    o_rsp_status = ST_ERRFULL;
  end else begin
    o_rsp_status = ST_OKAY;
  end
end

// Pushed slot for push, freed top for pop/inv
always_comb begin
  if (i_lk_is_push) begin
    o_rsp_ptr = i_lk_ptr;
  end else if (i_lk_is_pop | i_lk_is_inv) begin
    o_rsp_ptr = head_cur;
  end else begin
    o_rsp_ptr = '0;
  end
end

assign o_rsp_vld   = i_lk_vld;
assign o_rsp_op    = i_lk_op;
assign o_rsp_engid = i_lk_engid;
assign o_rsp_dat   = rd_dat;

// Head, tail and empty update
always_ff @(posedge clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    for (int e = 0; e < ENGS_N; e++) begin
      head_r[e] <= '0;
      tail_r[e] <= '0;
    end
    empty_r <= '1;
  end else if (push_ok) begin
    head_r[i_lk_engid] <= i_lk_ptr;
    // First entry is also the bottom of the stack
    if (eng_empty) begin
      tail_r[i_lk_engid]  <= i_lk_ptr;
      empty_r[i_lk_engid] <= 1'b0;
    end
  end else if (pull_ok) begin
    // Removing the last entry
    if (head_cur == tail_cur) begin
      empty_r[i_lk_engid] <= 1'b1;
    end else begin
      head_r[i_lk_engid] <= rd_link;
    end
  end
end

endmodule : stk_lookup

// ==== source/stk_cmd_in.sv ====
// Stack engine command input stage
// Samples the caller's command strobe and payload, and decodes the
// opcode into one-hot flags that are only high with the valid
module stk_cmd_in import stk_pkg::*; #(
  parameter int  ENGS_N  = ENGS_N_DEF
, parameter int  BANKS_N = BANKS_N_DEF
, parameter int  LINES_N = LINES_N_DEF
, parameter int  DAT_W   = DAT_W_DEF
, localparam int ENG_W   = $clog2(ENGS_N)
, localparam int PTR_W   = $clog2(BANKS_N) + $clog2(LINES_N)
) (
  input  logic             clk
, input  logic             i_rst_n
  // Command from the caller
, input  logic             i_cmd_vld
, input  opcode_e          i_cmd_op
, input  logic [ENG_W-1:0] i_cmd_engid
, input  logic             i_cmd_full
, input  logic [PTR_W-1:0] i_cmd_ptr
, input  logic [DAT_W-1:0] i_cmd_dat
  // Registered command towards lookup
, output logic             o_lk_vld
, output opcode_e          o_lk_op
, output logic             o_lk_is_push
, output logic             o_lk_is_pop
, output logic             o_lk_is_inv
, output logic [ENG_W-1:0] o_lk_engid
, output logic             o_lk_full
, output logic [PTR_W-1:0] o_lk_ptr
, output logic [DAT_W-1:0] o_lk_dat
);

// Strobe and decoded flags
always_ff @(posedge clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    o_lk_vld     <= 1'b0;
    o_lk_is_push <= 1'b0;
    o_lk_is_pop  <= 1'b0;
    o_lk_is_inv  <= 1'b0;
  end else begin
    o_lk_vld     <= i_cmd_vld;
    // NOP strobe leaves every flag low
    o_lk_is_push <= i_cmd_vld & (i_cmd_op == OP_PUSH);
    o_lk_is_pop  <= i_cmd_vld & (i_cmd_op == OP_POP);
    o_lk_is_inv  <= i_cmd_vld & (i_cmd_op == OP_INV);
  end
end

// Payload, only captured with the strobe
always_ff @(posedge clk) begin
  if (i_cmd_vld) begin
    o_lk_op    <= i_cmd_op;
    o_lk_engid <= i_cmd_engid;
    o_lk_full  <= i_cmd_full;
    o_lk_ptr   <= i_cmd_ptr;
    o_lk_dat   <= i_cmd_dat;
  end
end

endmodule : stk_cmd_in

// ==== source/stk_pkg.sv ====
// Stack engine shared definitions
// Command opcodes, response status codes and the default sizes
// that the top level hands down to every block
package stk_pkg;

  // Command opcode carried on the command strobe
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,
    OP_PUSH = 2'd1,
    OP_POP  = 2'd2,
    OP_INV  = 2'd3
  } opcode_e;

  // Response status
  typedef enum logic [1:0] {
    ST_OKAY     = 2'd0,
    ST_ERREMPTY = 2'd1,
    ST_ERRFULL  = 2'd2
  } status_e;

  // Number of independent stack contexts
  localparam int ENGS_N_DEF = 4;

  // Link and data storage is split over this many banks
  localparam int BANKS_N_DEF = 2;

  // Lines per bank
  localparam int LINES_N_DEF = 8;

  // Width of a pushed data word
  localparam int DAT_W_DEF = 32;

endpackage : stk_pkg
